/* tb/ring_patterns.hex */
// Columns: flags (claim, valid, resp, write, mask[3:0]), tag, addr, data
// Read data is predicted by the checker from earlier writes
DF01E000001011223344
D302E0000010AABBCCDD
CF03E000001000000000
DF10E0010020CAFEF00D
CF11E001002000000000
4F2012345678DEADBEEF
6F21E000001001020304
DF30E0000040A5A5A5A5
DF31E00100440F0F0F0F
CF32E000004000000000
D533E0000040FFFFFFFF
CF34E001004400000000
CF35E000004000000000
DF36E000004412345678
CF37E000004400000000
4F38E002000000000000
CF39E000001000000000

/* ring_mem_subsys.f */
common/mem_pkg.sv
common/ring_pkg.sv
common/mem_port_if.sv
hw/ring_delay.sv
hw/ring_sram.sv
ring_node/ring_mem_node.sv
hw/ring_mem_subsys.sv
tb/ring_checker.sv
tb/ring_mem_properties.sv
tb/ring_mem_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ring memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module ring_mem_subsys_tb \
  --Mdir obj_dir \
  -f ring_mem_subsys.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vring_mem_subsys_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "No verdict found in $LOG"
  exit 1
fi
exit 0

/* tb/ring_mem_subsys_tb.sv */
`timescale 1ns/1ps

module ring_mem_subsys_tb;

  localparam logic [31:0] FAST_BASE    = 32'hE000_0000;
  localparam logic [31:0] SLOW_BASE    = 32'hE001_0000;
  localparam logic [31:0] WIN_MASK     = 32'hFFFF_0000;
  localparam int          NUM_PATTERNS = 17;
  localparam int          WAIT_LIMIT   = 200;

  logic                        CLK;
  logic                        rst;
  logic [ring_pkg::RING_W-1:0] ring_in;
  logic [ring_pkg::RING_W-1:0] ring_out;
  logic                        exp_claim;

  int error_count;
  int done_count;
  int slow_done;
  int sent_count;
  int slow_sent;
  int tb_errors;

  // Claim flag in bit 79 above the request packet
  logic [79:0] patterns [NUM_PATTERNS];

  ring_mem_subsys #(
    .FAST_BASE (FAST_BASE),
    .SLOW_BASE (SLOW_BASE),
    .WIN_MASK  (WIN_MASK)
  ) i_ring_mem_subsys (
    .CLK      (CLK),
    .rst      (rst),
    .ring_in  (ring_in),
    .ring_out (ring_out)
  );

  ring_checker #(
    .FAST_BASE (FAST_BASE),
    .SLOW_BASE (SLOW_BASE),
    .WIN_MASK  (WIN_MASK)
  ) u_checker (
    .CLK         (CLK),
    .rst         (rst),
    .ring_in     (ring_in),
    .exp_claim   (exp_claim),
    .ring_out    (ring_out),
    .error_count (error_count),
    .done_count  (done_count),
    .slow_done   (slow_done)
  );

  always #10 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic is_slow_request(input logic [79:0] entry);
    return entry[79] && ((entry[63:32] & WIN_MASK) == SLOW_BASE);
  endfunction

  task automatic send_slot(input logic [78:0] pkt, input logic claimed);
    @(posedge CLK);
    ring_in   <= pkt;
    exp_claim <= claimed;
  endtask

  task automatic idle_slot();
    @(posedge CLK);
    ring_in   <= '0;
    exp_claim <= 1'b0;
  endtask

  // One slow request at a time
  task automatic wait_slow_idle();
    int n;
    n = 0;
    while (slow_done != slow_sent && n < WAIT_LIMIT) begin
      idle_slot();
      n++;
    end
    if (slow_done != slow_sent) begin
      tb_errors++;
      $display("Timed out waiting for the slow response at %0t", $time);
    end
  endtask

  task automatic wait_all_closed();
    int n;
    n = 0;
    while (done_count != sent_count && n < WAIT_LIMIT) begin
      idle_slot();
      n++;
    end
    if (done_count != sent_count) begin
      tb_errors++;
      $display("Timed out with %0d requests still missing on ring_out",
               sent_count - done_count);
    end
  endtask

  initial begin
    logic [79:0] entry;
    logic [31:0] rnd;
    int          total;
    CLK        = 1'b0;
    rst        = 1'b1;
    ring_in    = '0;
    exp_claim  = 1'b0;
    tb_errors  = 0;
    sent_count = 0;
    slow_sent  = 0;
    rnd        = 32'h8819;
    $readmemh("tb/ring_patterns.hex", patterns);

    repeat (16) @(posedge CLK);
    rst <= 1'b0;
    repeat (4) idle_slot();

    for (int i = 0; i < NUM_PATTERNS; i++) begin
      entry = patterns[i];
      if (is_slow_request(entry)) begin
        wait_slow_idle();
      end
      rnd = xorshift32(rnd);
      repeat (rnd[1:0]) idle_slot();
      send_slot(entry[78:0], entry[79]);
      if (entry[78]) begin
        sent_count++;
      end
      if (is_slow_request(entry)) begin
        slow_sent++;
      end
    end
    idle_slot();
    wait_all_closed();
    repeat (4) idle_slot();

    total = error_count + tb_errors;
    $display("Errors: checker %0d, testbench %0d", error_count, tb_errors);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tb/ring_mem_properties.sv */
`timescale 1ns/1ps

module ring_mem_properties (
  input logic                CLK,
  input logic                rst,
  input ring_pkg::ring_pkt_t pkt_in,
  input ring_pkg::ring_pkt_t pkt_out,
  input logic                cs_q,
  input logic                done_now,
  input ring_pkg::ring_pkt_t req_q
);

  // Empty ring during reset and in the cycle after
  a_reset_empty: assert property (@(posedge CLK)
    ($past(rst) || $past(rst, 2)) |-> !pkt_out.valid)
    else $error("Node put a valid slot out during or right after reset");

  // Memory request held while the SRAM stalls
  a_wait_stable: assert property (@(posedge CLK) disable iff (rst)
    (cs_q && !done_now) |=> (cs_q && $stable(req_q)))
    else $error("Memory request changed while wait was high");

  a_resp_passes: assert property (@(posedge CLK) disable iff (rst)
    (!$past(rst) && !$past(rst, 2) && $past(pkt_in.valid, 2) && $past(pkt_in.resp, 2))
    |-> (pkt_out == $past(pkt_in, 2)))
    else $error("Response packet was altered by a node");

endmodule

bind ring_mem_node ring_mem_properties i_props (
  .CLK      (CLK),
  .rst      (rst),
  .pkt_in   (pkt_in),
  .pkt_out  (pkt_out),
  .cs_q     (cs_q),
  .done_now (done_now),
  .req_q    (req_q)
);

/* tb/ring_checker.sv */
`timescale 1ns/1ps

module ring_checker #(
  parameter logic [31:0] FAST_BASE    = 32'hE000_0000,
  parameter logic [31:0] SLOW_BASE    = 32'hE001_0000,
  parameter logic [31:0] WIN_MASK     = 32'hFFFF_0000,
  parameter int          FIXED_LAT    = 9,
  parameter int          SLOW_MAX_LAT = 80
) (
  input  logic                        CLK,
  input  logic                        rst,
  input  logic [ring_pkg::RING_W-1:0] ring_in,
  input  logic                        exp_claim,
  input  logic [ring_pkg::RING_W-1:0] ring_out,
  output int                          error_count,
  output int                          done_count,
  output int                          slow_done
);

  ring_pkg::ring_pkt_t in_pkt;
  ring_pkg::ring_pkt_t out_pkt;

  // Expected output per tag
  ring_pkg::ring_pkt_t exp_pkt [256];
  int                  exp_cyc [256];
  logic                exp_slow [256];
  logic                pending [256];

  // Reference copies of both memories
  logic [31:0] fast_mem [256];
  logic [31:0] slow_mem [256];

  int cyc;
  int errors;
  int done_n;
  int slow_done_n;

  assign in_pkt  = ring_in;
  assign out_pkt = ring_out;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  mask);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic record_input(input ring_pkg::ring_pkt_t pkt, input logic claimed);
    ring_pkg::ring_pkt_t exp;
    logic                is_fast;
    logic                is_slow;
    exp     = pkt;
    is_fast = (pkt.addr & WIN_MASK) == FAST_BASE;
    is_slow = (pkt.addr & WIN_MASK) == SLOW_BASE;
    if (pending[pkt.tag]) begin
      errors++;
      $display("Tag %02h entered the ring at %0t while still open", pkt.tag, $time);
    end
    if (claimed) begin
      if (!is_fast && !is_slow) begin
        errors++;
        $display("Request with tag %02h is marked claimed but lies in no window", pkt.tag);
      end
      exp.resp = 1'b1;
      if (pkt.write) begin
        if (is_fast) begin
          fast_mem[pkt.addr[9:2]] = merge_bytes(fast_mem[pkt.addr[9:2]], pkt.data, pkt.mask);
        end else begin
          slow_mem[pkt.addr[9:2]] = merge_bytes(slow_mem[pkt.addr[9:2]], pkt.data, pkt.mask);
        end
      end else begin
        exp.data = is_fast ? fast_mem[pkt.addr[9:2]] : slow_mem[pkt.addr[9:2]];
      end
    end
    exp_pkt[pkt.tag]  = exp;
    exp_cyc[pkt.tag]  = cyc;
    exp_slow[pkt.tag] = claimed && is_slow;
    pending[pkt.tag]  = 1'b1;
  endtask

  task automatic check_output(input ring_pkg::ring_pkt_t pkt);
    int lat;
    if (!pending[pkt.tag]) begin
      errors++;
      $display("Unexpected slot with tag %02h on ring_out at %0t, no request is open",
               pkt.tag, $time);
      return;
    end
    lat = cyc - exp_cyc[pkt.tag];
    if (pkt !== exp_pkt[pkt.tag]) begin
      errors++;
      $display("error t=%0t ring_out expected %h actual %h", $time, exp_pkt[pkt.tag], pkt);
    end
    if (exp_slow[pkt.tag]) begin
      if (lat < FIXED_LAT || lat > SLOW_MAX_LAT) begin
        errors++;
        $display("error t=%0t ring_out_latency expected %0d..%0d actual %0d",
                 $time, FIXED_LAT, SLOW_MAX_LAT, lat);
      end
      slow_done_n++;
    end else if (lat != FIXED_LAT) begin
      errors++;
      $display("error t=%0t ring_out_latency expected %0d actual %0d", $time, FIXED_LAT, lat);
    end
    pending[pkt.tag] = 1'b0;
    done_n++;
  endtask

  always @(posedge CLK) begin
    if (rst) begin
      cyc         = 0;
      errors      = 0;
      done_n      = 0;
      slow_done_n = 0;
      for (int t = 0; t < 256; t++) begin
        pending[t] = 1'b0;
      end
    end else begin
      cyc++;
      if (out_pkt.valid) begin
        check_output(out_pkt);
      end
      if (in_pkt.valid) begin
        record_input(in_pkt, exp_claim);
      end
    end
    error_count <= errors;
    done_count  <= done_n;
    slow_done   <= slow_done_n;
  end

endmodule

/* hw/ring_mem_subsys.sv */
`timescale 1ns/1ps

module ring_mem_subsys #(
  parameter int                 IN_DELAY    = 2,
  parameter int                 OUT_DELAY   = 3,
  parameter mem_pkg::mem_addr_t FAST_BASE   = 32'hE000_0000,
  parameter mem_pkg::mem_addr_t SLOW_BASE   = 32'hE001_0000,
  parameter mem_pkg::mem_addr_t WIN_MASK    = 32'hFFFF_0000,
  parameter int                 SLOW_WAIT   = 7,
  parameter int                 DEPTH_WORDS = 256
) (
  input  logic                       CLK,
  input  logic                       rst,
  input  logic [ring_pkg::RING_W-1:0] ring_in,
  output logic [ring_pkg::RING_W-1:0] ring_out
);

  ring_pkg::ring_pkt_t in_to_fast;
  ring_pkg::ring_pkt_t fast_to_slow;
  ring_pkg::ring_pkt_t slow_to_out;

  mem_port_if fast_port ();
  mem_port_if slow_port ();

  ring_delay #(.DELAY_CYCLES(IN_DELAY)) u_delay_in (
    .CLK     (CLK),
    .rst     (rst),
    .pkt_in  (ring_in),
    .pkt_out (in_to_fast)
  );

  ring_mem_node #(.WIN_BASE(FAST_BASE), .WIN_MASK(WIN_MASK)) u_node_fast (
    .CLK     (CLK),
    .rst     (rst),
    .pkt_in  (in_to_fast),
    .pkt_out (fast_to_slow),
    .mem     (fast_port.node)
  );

  ring_sram #(.WAIT_CYCLES(0), .DEPTH_WORDS(DEPTH_WORDS)) u_sram_fast (
    .CLK (CLK),
    .rst (rst),
    .mem (fast_port.memory)
  );

  ring_mem_node #(.WIN_BASE(SLOW_BASE), .WIN_MASK(WIN_MASK)) u_node_slow (
    .CLK     (CLK),
    .rst     (rst),
    .pkt_in  (fast_to_slow),
    .pkt_out (slow_to_out),
    .mem     (slow_port.node)
  );

  // Slow memory stalls each access for SLOW_WAIT cycles
  ring_sram #(.WAIT_CYCLES(SLOW_WAIT), .DEPTH_WORDS(DEPTH_WORDS)) u_sram_slow (
    .CLK (CLK),
    .rst (rst),
    .mem (slow_port.memory)
  );

  ring_delay #(.DELAY_CYCLES(OUT_DELAY)) u_delay_out (
    .CLK     (CLK),
    .rst     (rst),
    .pkt_in  (slow_to_out),
    .pkt_out (ring_out)
  );

endmodule

/* ring_node/ring_mem_node.sv */
`timescale 1ns/1ps

module ring_mem_node #(
  parameter mem_pkg::mem_addr_t WIN_BASE = 32'hE000_0000,
  parameter mem_pkg::mem_addr_t WIN_MASK = 32'hFFFF_0000
) (
  input  logic                CLK,
  input  logic                rst,
  input  ring_pkg::ring_pkt_t pkt_in,
  output ring_pkg::ring_pkt_t pkt_out,
  mem_port_if.node            mem
);

  // Slot pipeline
  ring_pkg::ring_pkt_t s1;
  ring_pkg::ring_pkt_t s2;
  logic                s1_claim;
  logic                s2_claim;

  // Captured request, later reused as the held response
  ring_pkg::ring_pkt_t req_q;
  logic                busy;
  logic                cs_q;
  logic                rd_pend;
  logic                hold_valid;

  logic in_win;
  logic done_now;
  logic imm_done;
  logic insert;
  logic can_claim;
  logic claim;

  assign in_win   = (pkt_in.addr & WIN_MASK) == WIN_BASE;
  assign done_now = cs_q && !mem.wait_req;
  // Claimed slot still in stage 1 when the access finishes
  assign imm_done = done_now && s1_claim;
  assign insert   = hold_valid && !s2.valid;

  assign can_claim = !busy || imm_done || insert;
  assign claim     = pkt_in.valid && !pkt_in.resp && in_win && can_claim;

  assign mem.cs    = cs_q;
  assign mem.we    = req_q.write;
  assign mem.addr  = req_q.addr;
  assign mem.mask  = req_q.mask;
  assign mem.wdata = req_q.data;

  always_ff @(posedge CLK) begin
    s1 <= pkt_in;
    s2 <= s1;
    // A claimed slot that cannot be answered in place leaves a hole
    if (s1_claim && !imm_done) begin
      s2.valid <= 1'b0;
    end
    if (rst) begin
      s1.valid <= 1'b0;
      s2.valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (claim) begin
      req_q <= pkt_in;
    end else if (rd_pend && !req_q.write) begin
      req_q.data <= mem.rdata;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      s1_claim   <= 1'b0;
      s2_claim   <= 1'b0;
      busy       <= 1'b0;
      cs_q       <= 1'b0;
      rd_pend    <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      s1_claim <= claim;
      s2_claim <= imm_done;
      rd_pend  <= done_now && !s1_claim;

      if (claim) begin
        cs_q <= 1'b1;
      end else if (done_now) begin
        cs_q <= 1'b0;
      end

      if (claim) begin
        busy <= 1'b1;
      end else if (imm_done || insert) begin
        busy <= 1'b0;
      end

      if (rd_pend) begin
        hold_valid <= 1'b1;
      end else if (insert) begin
        hold_valid <= 1'b0;
      end
    end
  end

  // Stage 2 output: in-place response, held response, or pass-through
  always_comb begin
    pkt_out = s2;
    if (s2_claim) begin
      pkt_out.resp = 1'b1;
      if (!s2.write) begin
        pkt_out.data = mem.rdata;
      end
    end else if (insert) begin
      pkt_out      = req_q;
      pkt_out.resp = 1'b1;
    end
  end

endmodule

/* hw/ring_sram.sv */
`timescale 1ns/1ps

module ring_sram #(
  parameter int WAIT_CYCLES = 0,
  parameter int DEPTH_WORDS = 256
) (
  input logic        CLK,
  input logic        rst,
  mem_port_if.memory mem
);

  localparam int IDX_W = $clog2(DEPTH_WORDS);
  localparam int OFS_W = $clog2(mem_pkg::MASK_W);
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  mem_pkg::mem_data_t words [DEPTH_WORDS];
  logic [CNT_W-1:0]   wait_cnt;
  logic [IDX_W-1:0]   idx;
  logic               access;

  assign idx          = mem.addr[OFS_W +: IDX_W];
  assign mem.wait_req = mem.cs && (wait_cnt != '0);
  assign access       = mem.cs && !mem.wait_req;

  // Reload while deselected, count down through the first cycles of cs
  always_ff @(posedge CLK) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (!mem.cs) begin
      wait_cnt <= CNT_W'(WAIT_CYCLES);
    end else if (wait_cnt != '0) begin
      wait_cnt <= wait_cnt - CNT_W'(1);
    end
  end

  always_ff @(posedge CLK) begin
    if (access && mem.we) begin
      for (int b = 0; b < mem_pkg::MASK_W; b++) begin
        if (mem.mask[b]) begin
          words[idx][b*mem_pkg::BYTE_W +: mem_pkg::BYTE_W] <=
            mem.wdata[b*mem_pkg::BYTE_W +: mem_pkg::BYTE_W];
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      mem.rdata <= '0;
    end else if (access && !mem.we) begin
      mem.rdata <= words[idx];
    end
  end

endmodule

/* hw/ring_delay.sv */
`timescale 1ns/1ps

module ring_delay #(
  parameter int DELAY_CYCLES = 2
) (
  input  logic                CLK,
  input  logic                rst,
  input  ring_pkg::ring_pkt_t pkt_in,
  output ring_pkg::ring_pkt_t pkt_out
);

  ring_pkg::ring_pkt_t stage [DELAY_CYCLES];

  always_ff @(posedge CLK) begin
    stage[0] <= pkt_in;
    for (int i = 1; i < DELAY_CYCLES; i++) begin
      stage[i] <= stage[i-1];
    end
    // Only the valid bits matter for an empty ring
    if (rst) begin
      for (int i = 0; i < DELAY_CYCLES; i++) begin
        stage[i].valid <= 1'b0;
      end
    end
  end

  assign pkt_out = stage[DELAY_CYCLES-1];

endmodule

/* common/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if;

  logic               cs;
  logic               we;
  mem_pkg::mem_addr_t addr;
  mem_pkg::mem_mask_t mask;
  mem_pkg::mem_data_t wdata;
  mem_pkg::mem_data_t rdata;
  // Memory stall, high while the current access is held off
  logic               wait_req;

  modport node (
    output cs, we, addr, mask, wdata,
    input  rdata, wait_req
  );

  modport memory (
    input  cs, we, addr, mask, wdata,
    output rdata, wait_req
  );

endinterface

/* common/ring_pkg.sv */
package ring_pkg;

  // Source tag picked by the sender and echoed in the response
  localparam int TAG_W = 8;

  typedef logic [TAG_W-1:0] ring_tag_t;

  // One ring slot, valid is the MSB
  typedef struct packed {
    logic               valid;
    logic               resp;
    logic               write;
    mem_pkg::mem_mask_t mask;
    ring_tag_t          tag;
    mem_pkg::mem_addr_t addr;
    mem_pkg::mem_data_t data;
  } ring_pkt_t;

  // 79 bits with the current field widths
  localparam int RING_W = $bits(ring_pkt_t);

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

  // Memory port geometry, shared by the nodes and the SRAMs
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int MASK_W = 4;

  // One mask bit per byte lane
  localparam int BYTE_W = DATA_W / MASK_W;

  typedef logic [ADDR_W-1:0] mem_addr_t;
  typedef logic [DATA_W-1:0] mem_data_t;
  typedef logic [MASK_W-1:0] mem_mask_t;

endpackage
